// File: lmg_pkg.sv
package lmg_pkg;

	// board word: 64 squares of 4 bits, rank 1 in the low 32 bits, file a lowest
	localparam int NUM_FILES = 8;
	localparam int SQ_W      = 4;  // colour bit on top of a 3-bit piece code
	localparam int RANK_W    = NUM_FILES * SQ_W;
	localparam int BOARD_W   = RANK_W * NUM_FILES;

	// move word [flag][from][to]
	localparam int FLAG_W = 7;
	localparam int POS_W  = 6;  // file * 8 + rank
	localparam int MOVE_W = FLAG_W + 2 * POS_W;

	localparam logic WHITE = 1'b0;
	localparam logic BLACK = 1'b1;

	localparam logic [2:0] EMPTY = 3'o0;
	localparam logic [2:0] PAWN  = 3'o1;
	localparam logic [2:0] ROOK  = 3'o4;
	localparam logic [2:0] KING  = 3'o6;

	// flag bits, msb first
	// invalid, promote, pawn move, pawn two-square, en passant, castle, capture
	localparam logic [FLAG_W-1:0] CAS_HEAD = 7'b0000010;
	localparam logic [FLAG_W-1:0] ENP_HEAD = 7'b0010101;

	localparam logic [POS_W-1:0] SQ_E1 = 6'o40;
	localparam logic [POS_W-1:0] SQ_G1 = 6'o60;
	localparam logic [POS_W-1:0] SQ_C1 = 6'o20;

	// low half of a square index
	localparam logic [POS_W/2-1:0] RANK5_IDX = 3'd4;
	localparam logic [POS_W/2-1:0] RANK6_IDX = 3'd5;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;

	// kingside, queenside, en passant low, en passant high
	localparam int NUM_SLOTS = 4;

endpackage

// File: move_if.sv
`timescale 1ns/100ps

interface move_if;
	import lmg_pkg::*;

	logic              req;      // move valid, held until ack
	logic              ack;
	logic [MOVE_W-1:0] move;
	logic              finished; // scan over, nothing outstanding

	modport sender (
		output req, move, finished,
		input  ack
	);

	modport receiver (
		input  req, move, finished,
		output ack
	);

endinterface

// File: board_capture.sv
`timescale 1ns/100ps

module board_capture (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         board_req,
	output logic                         board_ack,
	input  logic [lmg_pkg::BOARD_W-1:0]  bstate,
	input  logic                         lcas_flag,
	input  logic                         rcas_flag,
	input  logic [lmg_pkg::NUM_FILES-1:0] enp_flags,
	input  logic                         busy,
	output logic                         start,
	output logic [lmg_pkg::RANK_W-1:0]   rank1_sq,
	output logic [lmg_pkg::RANK_W-1:0]   rank5_sq,
	output logic                         lcas,
	output logic                         rcas,
	output logic [lmg_pkg::NUM_FILES-1:0] enp_sel
);
	import lmg_pkg::*;

	logic                 accept;
	logic [NUM_FILES-1:0] enp_low;

	// new board only once the previous ack is gone and the scan has stopped
	assign accept = board_req && !board_ack && !busy;

	// only one en passant target can exist, keep the lowest file
	assign enp_low = enp_flags & (~enp_flags + 1'b1);

	always_ff @(posedge clk) begin
		if (reset) begin
			board_ack <= 1'b0;
			start     <= 1'b0;
		end else begin
			start <= accept;
			if (accept)
				board_ack <= 1'b1;
			else if (board_ack && !board_req)
				board_ack <= 1'b0; // source released, close the handshake
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rank1_sq <= bstate[RANK_W-1:0];
			rank5_sq <= bstate[RANK5_IDX*RANK_W +: RANK_W];
			lcas     <= lcas_flag;
			rcas     <= rcas_flag;
			enp_sel  <= enp_low;
		end
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(board_ack) |-> $past(board_req));

endmodule

// File: special_move_gen.sv
`timescale 1ns/100ps

module special_move_gen (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  logic [lmg_pkg::RANK_W-1:0]    rank1_sq,
	input  logic [lmg_pkg::RANK_W-1:0]    rank5_sq,
	input  logic                          lcas,
	input  logic                          rcas,
	input  logic [lmg_pkg::NUM_FILES-1:0] enp_sel,
	output logic                          busy,
	move_if.sender                        mv
);
	import lmg_pkg::*;

	logic [SQ_W-1:0] r1 [NUM_FILES];
	logic [SQ_W-1:0] r5 [NUM_FILES];

	logic [$clog2(NUM_SLOTS)-1:0] slot;
	logic                         active;
	logic                         sent;   // slot move acknowledged, waiting for ack to drop
	logic                         last_slot;
	logic                         step;
	logic                         launch;

	logic [2:0] enp_file;
	logic [2:0] lo_file;
	logic [2:0] hi_file;
	logic       enp_any;
	logic       cas_k;
	logic       cas_q;
	logic       enp_lo;
	logic       enp_hi;

	logic              slot_valid;
	logic [MOVE_W-1:0] slot_word;

	always_comb begin
		for (int f = 0; f < NUM_FILES; f++) begin
			r1[f] = rank1_sq[f*SQ_W +: SQ_W];
			r5[f] = rank5_sq[f*SQ_W +: SQ_W];
		end
	end

	always_comb begin
		enp_file = '0;
		for (int f = NUM_FILES - 1; f >= 0; f--) begin
			if (enp_sel[f])
				enp_file = 3'(f);
		end
	end

	assign enp_any = |enp_sel;
	assign lo_file = enp_file - 3'd1;
	assign hi_file = enp_file + 3'd1;

	// e1 king, f1 g1 clear, h1 rook
	assign cas_k = rcas && (r1[4] == {WHITE, KING}) && (r1[5][2:0] == EMPTY) &&
		(r1[6][2:0] == EMPTY) && (r1[7] == {WHITE, ROOK});
	// e1 king, b1 c1 d1 clear, a1 rook
	assign cas_q = lcas && (r1[4] == {WHITE, KING}) && (r1[1][2:0] == EMPTY) &&
		(r1[2][2:0] == EMPTY) && (r1[3][2:0] == EMPTY) && (r1[0] == {WHITE, ROOK});

	// black pawn just moved two squares, white pawn beside it on rank 5
	assign enp_lo = enp_any && (enp_file != 3'd0) && (r5[enp_file] == {BLACK, PAWN}) &&
		(r5[lo_file] == {WHITE, PAWN});
	assign enp_hi = enp_any && (int'(enp_file) != NUM_FILES - 1) &&
		(r5[enp_file] == {BLACK, PAWN}) && (r5[hi_file] == {WHITE, PAWN});

	always_comb begin
		case (slot)
			2'd0: begin
				slot_valid = cas_k;
				slot_word  = {CAS_HEAD, SQ_E1, SQ_G1};
			end
			2'd1: begin
				slot_valid = cas_q;
				slot_word  = {CAS_HEAD, SQ_E1, SQ_C1};
			end
			2'd2: begin
				slot_valid = enp_lo;
				slot_word  = {ENP_HEAD, lo_file, RANK5_IDX, enp_file, RANK6_IDX};
			end
			default: begin
				slot_valid = enp_hi;
				slot_word  = {ENP_HEAD, hi_file, RANK5_IDX, enp_file, RANK6_IDX};
			end
		endcase
	end

	assign last_slot = (int'(slot) == NUM_SLOTS - 1);
	assign launch    = active && !mv.req && !sent && slot_valid;
	// move on once the slot is skipped or its handshake has fully closed
	assign step      = active && !mv.req && (sent ? !mv.ack : !slot_valid);
	assign busy      = active;

	always_ff @(posedge clk) begin
		if (reset) begin
			active      <= 1'b0;
			slot        <= '0;
			sent        <= 1'b0;
			mv.req      <= 1'b0;
			mv.finished <= 1'b0;
		end else begin
			if (start) begin
				active      <= 1'b1;
				slot        <= '0;
				mv.finished <= 1'b0;
			end else if (step) begin
				if (last_slot) begin
					active      <= 1'b0;
					mv.finished <= 1'b1;
				end else begin
					slot <= slot + 1'b1;
				end
			end
			if (launch)
				mv.req <= 1'b1;
			else if (mv.req && mv.ack)
				mv.req <= 1'b0;
			if (mv.req && mv.ack)
				sent <= 1'b1;
			else if (step)
				sent <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (launch)
			mv.move <= slot_word;
	end

	a_move_stable: assert property (@(posedge clk) disable iff (reset)
		mv.req |=> !mv.req || $stable(mv.move));

endmodule

// File: move_fifo.sv
`timescale 1ns/100ps

module move_fifo (
	input  logic                       clk,
	input  logic                       reset,
	move_if.receiver                   mv,
	input  logic                       start,
	input  logic                       rden,
	output logic [lmg_pkg::MOVE_W-1:0] move_out,
	output logic                       fifo_empty,
	output logic                       done
);
	import lmg_pkg::*;

	logic [MOVE_W-1:0] mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               full;
	logic               wr_en;
	logic               rd_en;

	assign full       = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign fifo_empty = (count == '0);
	// take the move on the first req cycle with room, ack is withheld when full
	assign wr_en      = mv.req && !mv.ack && !full;
	assign rd_en      = rden && !fifo_empty;
	assign move_out   = mem[rd_ptr]; // show-ahead head

	always_ff @(posedge clk) begin
		if (reset) begin
			mv.ack <= 1'b0;
		end else if (wr_en) begin
			mv.ack <= 1'b1;
		end else if (mv.ack && !mv.req) begin
			mv.ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= mv.move;
	end

	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else if (start)
			done <= 1'b0; // new board accepted
		else if (mv.finished && !mv.ack)
			done <= 1'b1;
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		$rose(mv.ack) |-> $past(!full));

endmodule

// File: lmg_top.sv
`timescale 1ns/100ps

module lmg_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          board_req,
	output logic                          board_ack,
	input  logic [lmg_pkg::BOARD_W-1:0]   bstate,
	input  logic                          lcas_flag,
	input  logic                          rcas_flag,
	input  logic [lmg_pkg::NUM_FILES-1:0] enp_flags,
	input  logic                          rden,
	output logic [lmg_pkg::MOVE_W-1:0]    move_out,
	output logic                          fifo_empty,
	output logic                          done
);
	import lmg_pkg::*;

	logic                 start;
	logic                 busy;
	logic [RANK_W-1:0]    rank1_sq;
	logic [RANK_W-1:0]    rank5_sq;
	logic                 lcas;
	logic                 rcas;
	logic [NUM_FILES-1:0] enp_sel;

	move_if mv_link ();

	board_capture i_capture (
		.clk(clk), .reset(reset),
		.board_req(board_req), .board_ack(board_ack), .bstate(bstate),
		.lcas_flag(lcas_flag), .rcas_flag(rcas_flag), .enp_flags(enp_flags),
		.busy(busy), .start(start), .rank1_sq(rank1_sq), .rank5_sq(rank5_sq),
		.lcas(lcas), .rcas(rcas), .enp_sel(enp_sel)
	);

	special_move_gen i_gen (
		.clk(clk), .reset(reset), .start(start),
		.rank1_sq(rank1_sq), .rank5_sq(rank5_sq),
		.lcas(lcas), .rcas(rcas), .enp_sel(enp_sel),
		.busy(busy), .mv(mv_link.sender)
	);

	move_fifo i_fifo (
		.clk(clk), .reset(reset), .mv(mv_link.receiver), .start(start),
		.rden(rden), .move_out(move_out), .fifo_empty(fifo_empty), .done(done)
	);

endmodule

// File: tb_lmg_top.sv
`timescale 1ns/100ps

module tb_lmg_top;
	import lmg_pkg::*;

	localparam int NUM_BOARDS = 80;
	localparam int R5_BASE    = 4 * RANK_W; // rank 5 sits above four ranks

	logic                 clk;
	logic                 reset;
	logic                 board_req;
	logic                 board_ack;
	logic [BOARD_W-1:0]   bstate;
	logic                 lcas_flag;
	logic                 rcas_flag;
	logic [NUM_FILES-1:0] enp_flags;
	logic                 rden;
	logic [MOVE_W-1:0]    move_out;
	logic                 fifo_empty;
	logic                 done;

	logic [31:0]       rng_state = 32'd65331;
	logic [MOVE_W-1:0] exp_q [$]; // moves still owed by the FIFO, oldest first

	lmg_top i_dut (
		.clk(clk), .reset(reset),
		.board_req(board_req), .board_ack(board_ack), .bstate(bstate),
		.lcas_flag(lcas_flag), .rcas_flag(rcas_flag), .enp_flags(enp_flags),
		.rden(rden), .move_out(move_out), .fifo_empty(fifo_empty), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [MOVE_W-1:0] move_word(input logic [FLAG_W-1:0] head,
			input int from_file, input int from_rank, input int to_file, input int to_rank);
		return {head, 6'(from_file * 8 + from_rank), 6'(to_file * 8 + to_rank)};
	endfunction

	task automatic make_board(output logic [BOARD_W-1:0] b, output logic lc,
			output logic rc, output logic [NUM_FILES-1:0] ep);
		logic [31:0] r;
		logic [31:0] x;
		int          t;
		for (int i = 0; i < NUM_FILES; i++)
			b[i*RANK_W +: RANK_W] = next_rand();
		r = next_rand();
		x = next_rand();
		if (r[1:0] != 2'b00) begin
			// both castles set up, empty squares keep a random colour bit
			b[0*SQ_W +: SQ_W] = {WHITE, ROOK};
			b[4*SQ_W +: SQ_W] = {WHITE, KING};
			b[7*SQ_W +: SQ_W] = {WHITE, ROOK};
			for (int f = 1; f < 7; f++)
				if (f != 4)
					b[f*SQ_W +: SQ_W] = {x[f], EMPTY};
			if (r[3:2] == 2'b00)
				b[r[6:4]*SQ_W +: SQ_W] = x[11:8]; // spoil one square
		end
		lc = r[7] | r[8];
		rc = r[9] | r[10];
		t  = r[13:11];
		if (r[15:14] != 2'b00)
			b[R5_BASE + t*SQ_W +: SQ_W] = {BLACK, PAWN};
		if (r[16] && t > 0)
			b[R5_BASE + (t-1)*SQ_W +: SQ_W] = {WHITE, PAWN};
		if (r[17] && t < NUM_FILES - 1)
			b[R5_BASE + (t+1)*SQ_W +: SQ_W] = {WHITE, PAWN};
		if (r[19:18] != 2'b00) begin
			ep = 8'b1 << t;
			if (r[20])
				ep = ep | (x[19:12] & (8'hFF << (t + 1))); // extra files above target
		end else begin
			ep = x[27:20];
		end
	endtask

	// expected moves of one board, appended in slot order
	task automatic expect_moves(input logic [BOARD_W-1:0] b, input logic lc,
			input logic rc, input logic [NUM_FILES-1:0] ep);
		logic [SQ_W-1:0] sq1 [NUM_FILES];
		logic [SQ_W-1:0] sq5 [NUM_FILES];
		int              t;
		for (int f = 0; f < NUM_FILES; f++) begin
			sq1[f] = b[f*SQ_W +: SQ_W];
			sq5[f] = b[R5_BASE + f*SQ_W +: SQ_W];
		end
		if (rc && sq1[4] == {WHITE, KING} && sq1[5][2:0] == EMPTY &&
				sq1[6][2:0] == EMPTY && sq1[7] == {WHITE, ROOK})
			exp_q.push_back(move_word(CAS_HEAD, 4, 0, 6, 0));
		if (lc && sq1[4] == {WHITE, KING} && sq1[1][2:0] == EMPTY && sq1[2][2:0] == EMPTY &&
				sq1[3][2:0] == EMPTY && sq1[0] == {WHITE, ROOK})
			exp_q.push_back(move_word(CAS_HEAD, 4, 0, 2, 0));
		t = -1;
		for (int f = NUM_FILES - 1; f >= 0; f--)
			if (ep[f])
				t = f;
		if (t >= 0 && sq5[t] == {BLACK, PAWN}) begin
			if (t > 0)
				if (sq5[t-1] == {WHITE, PAWN})
					exp_q.push_back(move_word(ENP_HEAD, t - 1, 4, t, 5));
			if (t < NUM_FILES - 1)
				if (sq5[t+1] == {WHITE, PAWN})
					exp_q.push_back(move_word(ENP_HEAD, t + 1, 4, t, 5));
		end
	endtask

	task automatic load_board(input logic [BOARD_W-1:0] b, input logic lc,
			input logic rc, input logic [NUM_FILES-1:0] ep);
		int waited;
		@(posedge clk);
		bstate    <= b;
		lcas_flag <= lc;
		rcas_flag <= rc;
		enp_flags <= ep;
		board_req <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!board_ack) begin
			if (waited > 20)
				abort_run("board_ack never rose after board_req");
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		board_req <= 1'b0;
		@(negedge clk);
		assert (done == 1'b0)
			else abort_run($sformatf("mismatch done: got %h expected %h", done, 1'b0));
		waited = 0;
		while (board_ack) begin
			if (waited > 20)
				abort_run("board_ack stayed high after board_req dropped");
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (!done) begin
			if (waited > 100)
				abort_run("done never rose after the board was accepted");
			waited++;
			@(negedge clk);
		end
	endtask

	task automatic drain_fifo();
		logic [MOVE_W-1:0] want;
		while (1) begin
			@(negedge clk);
			if (fifo_empty)
				break;
			if (exp_q.size() == 0)
				abort_run("FIFO holds more moves than the boards produce");
			want = exp_q.pop_front();
			assert (move_out == want)
				else abort_run($sformatf("mismatch move_out: got %h expected %h", move_out, want));
			@(posedge clk);
			rden <= 1'b1;
			@(posedge clk);
			rden <= 1'b0;
		end
		assert (exp_q.size() == 0)
			else abort_run($sformatf("FIFO ran empty with %0d moves missing", exp_q.size()));
	endtask

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(board_ack) |-> $past(board_req))
		else abort_run("board_ack rose while board_req was low");

	a_ack_holds: assert property (@(posedge clk) disable iff (reset)
		$fell(board_ack) |-> !$past(board_req))
		else abort_run("board_ack fell while board_req was still high");

	initial begin
		repeat (NUM_BOARDS * 200) @(posedge clk);
		abort_run($sformatf("timeout after %0d cycles", NUM_BOARDS * 200));
	end

	initial begin
		logic [BOARD_W-1:0]   b;
		logic                 lc;
		logic                 rc;
		logic [NUM_FILES-1:0] ep;
		logic [31:0]          r;
		int                   boards;
		int                   group;
		reset     = 1'b1;
		board_req = 1'b0;
		bstate    = '0;
		lcas_flag = 1'b0;
		rcas_flag = 1'b0;
		enp_flags = '0;
		rden      = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!board_ack && !done && fifo_empty)
			else abort_run("outputs not idle after reset");
		boards = 0;
		while (boards < NUM_BOARDS) begin
			r = next_rand();
			group = (boards + 1 < NUM_BOARDS) ? 1 + r[0] : 1; // two boards stack up unread
			for (int g = 0; g < group; g++) begin
				make_board(b, lc, rc, ep);
				expect_moves(b, lc, rc, ep);
				load_board(b, lc, rc, ep);
				wait_done();
				boards++;
			end
			drain_fifo();
		end
		// pop request on an empty FIFO
		@(posedge clk);
		rden <= 1'b1;
		@(posedge clk);
		rden <= 1'b0;
		@(negedge clk);
		assert (fifo_empty)
			else abort_run("reading an empty FIFO left it non-empty");
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: lmg_top.f
lmg_pkg.sv
move_if.sv
board_capture.sv
special_move_gen.sv
move_fifo.sv
lmg_top.sv
tb_lmg_top.sv
